//--- source/bch_field_pkg.sv
package bch_field_pkg;

	localparam int max_m = 8;

	// primitive polynomials, bit m is the leading term.
	function automatic logic [max_m:0] prim_poly(input int m);
		logic [max_m:0] poly;
		case (m)
			2: poly = 9'h007;
			3: poly = 9'h00b;
			4: poly = 9'h013;
			5: poly = 9'h025;
			6: poly = 9'h043;
			7: poly = 9'h089;
			8: poly = 9'h11d;
			default: poly = '0; // unsupported field size.
		endcase
		return poly;
	endfunction

	// shift-and-add multiply with reduction after every shift.
	function automatic logic [max_m-1:0] gf_mul(
		input int m,
		input logic [max_m-1:0] a,
		input logic [max_m-1:0] b
	);
		logic [max_m:0] acc;
		logic [max_m:0] poly;
		acc = '0;
		poly = prim_poly(m);
		for (int i = max_m - 1; i >= 0; i--) begin
			if (i < m) begin
				acc = acc << 1;
				if (acc[m])
					acc = acc ^ poly;
				if (b[i])
					acc = acc ^ {1'b0, a};
			end
		end
		return acc[max_m-1:0];
	endfunction

	function automatic logic [max_m-1:0] gf_square(input int m, input logic [max_m-1:0] a);
		return gf_mul(m, a, a);
	endfunction

	// alpha^k, with alpha = x.
	function automatic logic [max_m-1:0] gf_alpha_pow(input int m, input int k);
		logic [max_m-1:0] r;
		int steps;
		r = max_m'(1);
		steps = k % ((1 << m) - 1);
		for (int i = 0; i < steps; i++)
			r = gf_mul(m, r, max_m'(2));
		return r;
	endfunction

endpackage

//--- source/bch_code_pkg.sv
package bch_code_pkg;

	function automatic int code_len(input int m);
		return (1 << m) - 1;
	endfunction

	function automatic int syn_words(input int t);
		return 2 * t - 1;
	endfunction

	function automatic int odd_count(input int t);
		return t;
	endfunction

	// counter value seen together with the last codeword bit.
	function automatic logic [bch_field_pkg::max_m-1:0] lfsr_terminal(input int m);
		return bch_field_pkg::gf_alpha_pow(m, code_len(m) - 2);
	endfunction

	function automatic int shuffle_load_index(input int t, input int i);
		int idx;
		if (t < 4 && i == t + 1)
			idx = 3 * t - i - 2; // fixed slot.
		else
			idx = (2 * t + 1 - i) % (2 * t - 1);
		return idx;
	endfunction

	function automatic int shuffle_rotate_index(input int t, input int i);
		return (i + 2 * t - 3) % (2 * t - 1);
	endfunction

endpackage

//--- source/syn_if.sv
`timescale 1ns/1ps

interface syn_if #(
	parameter int M = 4,
	parameter int T = 2
);
	import bch_code_pkg::*;

	logic done;
	logic [syn_words(T)-1:0][M-1:0] syn; // word k holds S(k+1).
	logic zero;
	logic accepted;

	modport calc (
		output done,
		output syn,
		output zero,
		input accepted
	);

	modport shuf (
		input done,
		input syn,
		input zero,
		input accepted
	);

endinterface

//--- source/bch_lfsr_counter.sv
`timescale 1ns/1ps

module bch_lfsr_counter #(
	parameter int M = 4
) (
	input logic clk,
	input logic restart,
	input logic ce,
	output logic [M-1:0] count
);
	import bch_field_pkg::*;

	localparam logic [max_m:0] poly = prim_poly(M);

	logic [M-1:0] feedback;

	// galois form, one step multiplies the state by alpha.
	assign feedback = count[M-1] ? poly[M-1:0] : '0;

	always_ff @(posedge clk) begin
		if (restart)
			count <= M'(1);
		else if (ce)
			count <= {count[M-2:0], 1'b0} ^ feedback;
	end

endmodule

//--- source/bch_syndrome_lane.sv
`timescale 1ns/1ps

module bch_syndrome_lane #(
	parameter int M = 4,
	parameter int J = 1
) (
	input logic clk,
	input logic start,
	input logic ce,
	input logic data_in,
	output logic [M-1:0] syn
);
	import bch_field_pkg::*;

	localparam logic [max_m-1:0] alpha_j = gf_alpha_pow(M, J);

	logic [max_m-1:0] prod;

	assign prod = gf_mul(M, max_m'(syn), alpha_j);

	// horner step, first bit ends up as the top coefficient.
	always_ff @(posedge clk) begin
		if (start)
			syn <= M'(data_in);
		else if (ce)
			syn <= prod[M-1:0] ^ M'(data_in);
	end

endmodule

//--- source/bch_syndrome.sv
`timescale 1ns/1ps

module bch_syndrome #(
	parameter int M = 4,
	parameter int T = 2
) (
	input logic clk,
	input logic rst,
	input logic start,
	input logic data_in,
	output logic busy,
	syn_if.calc sif
);
	import bch_field_pkg::*;
	import bch_code_pkg::*;

	localparam int words = syn_words(T);
	localparam int lanes = odd_count(T);
	localparam logic [max_m-1:0] terminal_full = lfsr_terminal(M);
	localparam logic [M-1:0] terminal = terminal_full[M-1:0];

	wire [words-1:0][M-1:0] syn_all;
	logic [lanes-1:0] lane_zero;
	logic [M-1:0] count;
	logic running;
	logic waiting;
	logic last_bit;

	assign last_bit = running && count == terminal;

	bch_lfsr_counter #(
		.M(M)
	) u_counter (
		.clk(clk),
		.restart(start),
		.ce(running && count != terminal), // holds at the terminal state.
		.count(count)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			running <= 1'b0;
			waiting <= 1'b0;
		end else begin
			if (start)
				running <= 1'b1;
			else if (last_bit)
				running <= 1'b0;

			if (last_bit)
				waiting <= 1'b1;
			else if (sif.accepted)
				waiting <= 1'b0;
		end
	end

	assign busy = waiting && !sif.accepted;
	assign sif.done = waiting;

	// odd syndromes, one horner register each.
	for (genvar k = 0; k < lanes; k++) begin : g_lane
		bch_syndrome_lane #(
			.M(M),
			.J(2 * k + 1)
		) u_lane (
			.clk(clk),
			.start(start),
			.ce(running),
			.data_in(data_in),
			.syn(syn_all[2 * k])
		);

		assign lane_zero[k] = syn_all[2 * k] == '0;
	end

	// S(2k) = S(k)^2 for binary codes.
	for (genvar j = 2; j <= words; j += 2) begin : g_even
		logic [max_m-1:0] sq;

		assign sq = gf_square(M, max_m'(syn_all[j / 2 - 1]));
		assign syn_all[j - 1] = sq[M-1:0];
	end

	assign sif.syn = syn_all;
	assign sif.zero = &lane_zero; // even words follow from the odd ones.

endmodule

//--- source/bch_syndrome_shuffle.sv
`timescale 1ns/1ps

module bch_syndrome_shuffle #(
	parameter int M = 4,
	parameter int T = 2
) (
	input logic clk,
	input logic rst,
	syn_if.shuf sif,
	input logic ce,
	output logic [bch_code_pkg::syn_words(T)*M-1:0] syn_shuffled
);
	import bch_code_pkg::*;

	localparam int words = syn_words(T);

	logic load;

	assign load = sif.done && sif.accepted;

	for (genvar i = 0; i < words; i++) begin : g_slot
		localparam int load_src = shuffle_load_index(T, i);
		localparam int rot_src = shuffle_rotate_index(T, i);

		if (T < 4 && i == T + 1) begin : g_fixed
			// this slot only changes on load.
			always_ff @(posedge clk) begin
				if (rst)
					syn_shuffled[i*M +: M] <= '0;
				else if (load)
					syn_shuffled[i*M +: M] <= sif.syn[load_src];
			end
		end else begin : g_rot
			always_ff @(posedge clk) begin
				if (rst)
					syn_shuffled[i*M +: M] <= '0;
				else if (load)
					syn_shuffled[i*M +: M] <= sif.syn[load_src];
				else if (ce)
					syn_shuffled[i*M +: M] <= syn_shuffled[rot_src*M +: M]; // one step.
			end
		end
	end

endmodule

//--- source/bch_syndrome_top.sv
`timescale 1ns/1ps

module bch_syndrome_top #(
	parameter int M = 4,
	parameter int T = 2
) (
	input logic clk,
	input logic rst,
	input logic start,
	input logic data_in,
	input logic accepted,
	input logic shuffle_ce,
	output logic busy,
	output logic done,
	output logic zero,
	output logic [bch_code_pkg::syn_words(T)*M-1:0] syn,
	output logic [bch_code_pkg::syn_words(T)*M-1:0] syn_shuffled
);

	syn_if #(
		.M(M),
		.T(T)
	) sif ();

	assign sif.accepted = accepted;
	assign done = sif.done;
	assign zero = sif.zero;
	assign syn = sif.syn;

	bch_syndrome #(
		.M(M),
		.T(T)
	) u_syndrome (
		.clk(clk),
		.rst(rst),
		.start(start),
		.data_in(data_in),
		.busy(busy),
		.sif(sif.calc)
	);

	bch_syndrome_shuffle #(
		.M(M),
		.T(T)
	) u_shuffle (
		.clk(clk),
		.rst(rst),
		.sif(sif.shuf),
		.ce(shuffle_ce),
		.syn_shuffled(syn_shuffled)
	);

endmodule

//--- verif/bch_syndrome_checker.sv
`timescale 1ns/1ps

module bch_syndrome_checker #(
	parameter int M = 4,
	parameter int T = 2
) (
	input logic clk,
	input logic rst,
	input logic start,
	input logic accepted,
	input logic busy,
	input logic done,
	input logic zero,
	input logic [bch_code_pkg::syn_words(T)*M-1:0] syn,
	input logic [bch_code_pkg::syn_words(T)*M-1:0] syn_shuffled,
	input logic [bch_code_pkg::syn_words(T)*M-1:0] exp_syn,
	input logic [bch_code_pkg::syn_words(T)*M-1:0] exp_shuf,
	input logic exp_zero,
	input logic [95:0] test_name,
	input int test_num,
	output int syn_errors,
	output int flag_errors,
	output int shuffle_errors,
	output int protocol_errors
);
	import bch_code_pkg::*;

	localparam int n = code_len(M);

	logic prev_rst;
	logic prev_done;
	logic prev_acc;
	logic counting;
	int cycles;

	initial begin
		syn_errors = 0;
		flag_errors = 0;
		shuffle_errors = 0;
		protocol_errors = 0;
		prev_rst = 1'b1;
		prev_done = 1'b0;
		prev_acc = 1'b0;
		counting = 1'b0;
		cycles = 0;
	end

	// outputs have settled well before the falling edge.
	always @(negedge clk) begin
		if (rst) begin
			prev_rst = 1'b1;
			prev_done = 1'b0;
			prev_acc = 1'b0;
			counting = 1'b0;
		end else begin
			if (prev_rst && (done !== 1'b0 || busy !== 1'b0)) begin
				$display("done or busy is high right after reset in %0s %0d", test_name, test_num);
				protocol_errors++;
			end
			if (start) begin
				cycles = 0; // cycle of the first bit.
				counting = 1'b1;
			end else if (counting) begin
				cycles++;
			end
			if (done === 1'b1 && !prev_done) begin
				if (!counting) begin
					$display("done rose without a start in %0s %0d", test_name, test_num);
					protocol_errors++;
				end else if (cycles != n) begin
					$display("mismatch %0s %0d done latency: expected %0d actual %0d",
						test_name, test_num, n, cycles);
					protocol_errors++;
				end
				counting = 1'b0;
			end
			if (prev_done && !prev_acc && done !== 1'b1) begin
				$display("done fell before the word was accepted in %0s %0d", test_name, test_num);
				protocol_errors++;
			end else if (prev_done && prev_acc && done === 1'b1) begin
				$display("done stayed high after the accepting cycle in %0s %0d",
					test_name, test_num);
				protocol_errors++;
			end
			if (done === 1'b1) begin
				if (syn !== exp_syn) begin
					$display("mismatch %0s %0d syn: expected %h actual %h",
						test_name, test_num, exp_syn, syn);
					syn_errors++;
				end
				if (zero !== exp_zero) begin
					$display("mismatch %0s %0d zero: expected %b actual %b",
						test_name, test_num, exp_zero, zero);
					flag_errors++;
				end
			end
			if (busy !== (done && !accepted)) begin
				$display("mismatch %0s %0d busy: expected %b actual %b",
					test_name, test_num, done && !accepted, busy);
				flag_errors++;
			end
			if (syn_shuffled !== exp_shuf) begin
				$display("mismatch %0s %0d syn_shuffled: expected %h actual %h",
					test_name, test_num, exp_shuf, syn_shuffled);
				shuffle_errors++;
			end
			prev_rst = 1'b0;
			prev_done = done === 1'b1;
			prev_acc = accepted;
		end
	end

endmodule

//--- verif/tb_bch_syndrome.sv
`timescale 1ns/1ps

module tb_bch_syndrome;
	import bch_field_pkg::*;
	import bch_code_pkg::*;

	localparam int M = 4;
	localparam int T = 2;
	localparam int n = code_len(M);
	localparam int words = syn_words(T);
	localparam int num_words = 36;
	localparam int max_delay = 8;
	localparam int idle_cycles = 6;
	localparam int margin = 20;
	localparam int watchdog_ns = (num_words + 2) * (n + max_delay + idle_cycles + margin) * 10
		+ 200;

	logic clk;
	logic rst;
	logic start;
	logic data_in;
	logic accepted;
	logic shuffle_ce;
	logic busy;
	logic done;
	logic zero;
	logic [words*M-1:0] syn;
	logic [words*M-1:0] syn_shuffled;
	logic [words*M-1:0] exp_syn;
	logic [words*M-1:0] exp_shuf;
	logic exp_zero;
	logic [95:0] test_name;
	int test_num;
	int syn_errors;
	int flag_errors;
	int shuffle_errors;
	int protocol_errors;
	int seq_errors;
	int unsigned lcg_state = 10;
	logic [n-1:0] gen_poly;
	int gen_deg;

	bch_syndrome_top #(
		.M(M),
		.T(T)
	) dut0 (
		.clk(clk),
		.rst(rst),
		.start(start),
		.data_in(data_in),
		.accepted(accepted),
		.shuffle_ce(shuffle_ce),
		.busy(busy),
		.done(done),
		.zero(zero),
		.syn(syn),
		.syn_shuffled(syn_shuffled)
	);

	bch_syndrome_checker #(
		.M(M),
		.T(T)
	) u_checker (
		.clk(clk),
		.rst(rst),
		.start(start),
		.accepted(accepted),
		.busy(busy),
		.done(done),
		.zero(zero),
		.syn(syn),
		.syn_shuffled(syn_shuffled),
		.exp_syn(exp_syn),
		.exp_shuf(exp_shuf),
		.exp_zero(exp_zero),
		.test_name(test_name),
		.test_num(test_num),
		.syn_errors(syn_errors),
		.flag_errors(flag_errors),
		.shuffle_errors(shuffle_errors),
		.protocol_errors(protocol_errors)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16;
	endfunction

	function automatic int rand_below(input int k);
		return int'(lcg_next() % k);
	endfunction

	// direct evaluation of r(alpha^j), bit i is the coefficient of x^i.
	function automatic logic [words*M-1:0] model_syndromes(input logic [n-1:0] w);
		logic [words*M-1:0] s;
		logic [max_m-1:0] acc;
		s = '0;
		for (int j = 1; j <= words; j++) begin
			acc = '0;
			for (int i = 0; i < n; i++)
				if (w[i])
					acc = acc ^ gf_alpha_pow(M, i * j);
			s[(j-1)*M +: M] = acc[M-1:0];
		end
		return s;
	endfunction

	// an all-zero syndrome set marks an error-free word.
	function automatic logic model_zero(input logic [words*M-1:0] s);
		return s == '0;
	endfunction

	function automatic logic [words*M-1:0] load_shuffle(input logic [words*M-1:0] s);
		logic [words*M-1:0] r;
		int src;
		for (int i = 0; i < words; i++) begin
			src = (T < 4 && i == T + 1) ? 3 * T - i - 2 : (2 * T + 1 - i) % (2 * T - 1);
			r[i*M +: M] = s[src*M +: M];
		end
		return r;
	endfunction

	function automatic logic [words*M-1:0] rotate_shuffle(input logic [words*M-1:0] s);
		logic [words*M-1:0] r;
		r = s;
		for (int i = 0; i < words; i++)
			if (!(T < 4 && i == T + 1))
				r[i*M +: M] = s[((i + 2 * T - 3) % (2 * T - 1))*M +: M];
		return r;
	endfunction

	// kind 0 random bits, 1 all zero, 2 codeword with up to T flipped bits.
	function automatic logic [n-1:0] make_word(input int kind);
		logic [n-1:0] w;
		logic [n-1:0] flips;
		int nerr;
		int pos;
		w = '0;
		flips = '0;
		if (kind == 0) begin
			for (int i = 0; i < n; i++)
				w[i] = (lcg_next() % 2) == 1;
		end else if (kind == 2) begin
			for (int i = 0; i < n - gen_deg; i++)
				if ((lcg_next() % 2) == 1)
					w = w ^ (gen_poly << i);
			nerr = rand_below(T + 1);
			while (nerr > 0) begin
				pos = rand_below(n);
				if (!flips[pos]) begin
					flips[pos] = 1'b1;
					nerr--;
				end
			end
		end
		return w ^ flips;
	endfunction

	// product of (x + alpha^e) over the cyclotomic cosets of the odd powers.
	task automatic build_generator();
		logic [max_m-1:0] gp [0:n];
		logic [max_m-1:0] root;
		bit is_root [0:n-1];
		int e;
		for (int i = 0; i <= n; i++)
			gp[i] = '0;
		for (int i = 0; i < n; i++)
			is_root[i] = 1'b0;
		gp[0] = max_m'(1);
		gen_deg = 0;
		for (int j = 1; j < 2 * T; j += 2) begin
			e = j % n;
			for (int r = 0; r < M; r++) begin
				is_root[e] = 1'b1;
				e = (2 * e) % n;
			end
		end
		for (int r = 0; r < n; r++) begin
			if (is_root[r]) begin
				root = gf_alpha_pow(M, r);
				for (int i = gen_deg + 1; i >= 1; i--)
					gp[i] = gp[i-1] ^ gf_mul(M, gp[i], root);
				gp[0] = gf_mul(M, gp[0], root);
				gen_deg++;
			end
		end
		for (int i = 0; i < n; i++)
			gen_poly[i] = gp[i][0];
	endtask

	task automatic tick();
		@(posedge clk);
		shuffle_ce <= (lcg_next() % 4) == 0;
	endtask

	task automatic send_word(input logic [n-1:0] w, input int bits);
		for (int c = 0; c < bits; c++) begin
			tick();
			start <= (c == 0);
			data_in <= w[n-1-c]; // top coefficient first.
		end
		tick();
		start <= 1'b0;
		data_in <= 1'b0;
	endtask

	task automatic wait_done(output bit seen);
		int waited;
		seen = 1'b0;
		waited = 0;
		while (!seen && waited < n + 4) begin
			@(negedge clk);
			if (done === 1'b1)
				seen = 1'b1;
			else begin
				tick();
				waited++;
			end
		end
		if (!seen) begin
			$display("done did not rise within %0d cycles after the last bit", n + 4);
			seq_errors++;
		end
	endtask

	task automatic accept_word();
		int delay;
		delay = rand_below(max_delay);
		repeat (delay) tick();
		tick();
		accepted <= 1'b1;
		tick();
		accepted <= 1'b0;
		repeat (idle_cycles) tick();
	endtask

	task automatic run_word(input int kind, input logic [95:0] name);
		logic [n-1:0] w;
		logic [words*M-1:0] s;
		bit seen;
		w = make_word(kind);
		s = model_syndromes(w);
		test_name <= name;
		exp_syn <= s;
		exp_zero <= model_zero(s);
		send_word(w, n);
		wait_done(seen);
		if (seen)
			accept_word();
	endtask

	// shuffle register model, load on acceptance, else rotate on ce.
	always @(posedge clk) begin
		if (rst)
			exp_shuf <= '0;
		else if (accepted)
			exp_shuf <= load_shuffle(exp_syn);
		else if (shuffle_ce)
			exp_shuf <= rotate_shuffle(exp_shuf);
	end

	initial begin
		#(watchdog_ns);
		$display("watchdog expired after %0d ns", watchdog_ns);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		logic [n-1:0] w;
		int total;
		rst = 1'b1;
		start = 1'b0;
		data_in = 1'b0;
		accepted = 1'b0;
		shuffle_ce = 1'b0;
		test_name = "reset";
		test_num = 0;
		exp_syn = '0;
		exp_zero = 1'b0;
		seq_errors = 0;
		build_generator();
		repeat (4) tick();
		rst <= 1'b0;
		repeat (2) tick();
		for (int i = 0; i < num_words; i++) begin
			test_num <= i;
			case (i % 3)
				0: run_word(0, "random");
				1: run_word(1, "zero_word");
				default: run_word(2, "codeword");
			endcase
		end
		test_num <= num_words;
		test_name <= "reset_word";
		w = make_word(0);
		send_word(w, n / 2);
		rst <= 1'b1;
		repeat (4) tick();
		rst <= 1'b0;
		repeat (2) tick();
		test_num <= num_words + 1;
		run_word(2, "after_reset");
		repeat (4) tick();
		total = syn_errors + flag_errors + shuffle_errors + protocol_errors + seq_errors;
		$display("errors: syndrome %0d, flags %0d, shuffle %0d, protocol %0d, sequencing %0d",
			syn_errors, flag_errors, shuffle_errors, protocol_errors, seq_errors);
		if (total == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- vlog.f
source/bch_field_pkg.sv
source/bch_code_pkg.sv
source/syn_if.sv
source/bch_lfsr_counter.sv
source/bch_syndrome_lane.sv
source/bch_syndrome.sv
source/bch_syndrome_shuffle.sv
source/bch_syndrome_top.sv
verif/bch_syndrome_checker.sv
verif/tb_bch_syndrome.sv

//--- Makefile
SIM := obj_dir/Vtb_bch_syndrome

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): vlog.f $(wildcard source/*.sv verif/*.sv)
	verilator --binary --timing -Wno-fatal --top-module tb_bch_syndrome -f vlog.f

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
